/* logic/conv_macros.svh */
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// sample and weight width
`define DATA_W 8
// 3x3 window
`define TAPS 9
`define CODE_W 2

`define ACC_W 24
`define BIAS_W 16
`define ADDR_W 16

// map size and channel/kernel counts
`define DIM_W 6
`define CNT_W 10

// requantize back to int8
`define QUANT_SHIFT 5

`endif

/* logic/conv_pkg.sv */
`include "conv_macros.svh"

package conv_pkg;

	typedef logic signed [`DATA_W-1:0] data_t;
	typedef logic signed [`DATA_W-1:0] weight_t;

	// nine 2-bit codes, tap 0 in the low bits
	typedef logic [`TAPS*`CODE_W-1:0] code_word_t;
	// four int8 weights, code 0 in the low byte
	typedef logic [4*`DATA_W-1:0] codebook_t;

	typedef logic signed [`ACC_W-1:0] acc_t;
	typedef logic signed [`BIAS_W-1:0] bias_t;
	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`DIM_W-1:0] dim_t;
	typedef logic [`CNT_W-1:0] cnt_t;
	typedef logic [$clog2(`TAPS)-1:0] tap_t;

	typedef enum logic [2:0] {
		IDLE,
		BIAS,
		CODE,
		TAPS,
		MAC,
		WRITE,
		DONE
	} state_t;

endpackage

/* logic/conv_ctrl.sv */
`timescale 1ns/1ns
`include "conv_macros.svh"

module conv_ctrl (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  conv_pkg::dim_t   num_row,
	input  conv_pkg::cnt_t   num_channel,
	input  conv_pkg::cnt_t   num_kernel,
	output logic             finish,
	output conv_pkg::state_t state,
	output conv_pkg::dim_t   row,
	output conv_pkg::dim_t   col,
	output conv_pkg::cnt_t   ch,
	output conv_pkg::cnt_t   kernel,
	output conv_pkg::tap_t   tap,
	output logic             tap_req,
	output logic             code_rd,
	output conv_pkg::addr_t  code_addr,
	output logic             bias_rd,
	output conv_pkg::addr_t  bias_addr,
	output logic             bias_load,
	output logic             code_load,
	output logic             pixel_start,
	output logic             out_wr_req,
	output conv_pkg::addr_t  wr_addr,
	output conv_pkg::dim_t   map_size
);
	import conv_pkg::*;

	cnt_t n_ch;
	cnt_t n_ker;
	addr_t plane;
	// second cycle of a bias or code read
	logic step;

	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			map_size <= num_row;
			n_ch <= num_channel;
			n_ker <= num_kernel;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= IDLE;
			step <= 1'b0;
			tap <= '0;
			row <= '0;
			col <= '0;
			ch <= '0;
			kernel <= '0;
			finish <= 1'b0;
		end else begin
			case (state)
				IDLE: if (start) begin
					state <= BIAS;
					kernel <= '0;
					finish <= 1'b0;
				end
				BIAS: begin
					step <= ~step;
					if (step) begin
						state <= CODE;
						row <= '0;
						col <= '0;
						ch <= '0;
					end
				end
				CODE: begin
					step <= ~step;
					if (step) begin
						state <= TAPS;
						tap <= '0;
					end
				end
				TAPS: begin
					tap <= tap + 1'b1;
					if (tap == tap_t'(`TAPS - 1))
						state <= MAC;
				end
				// last tap lands here
				MAC: if (ch == n_ch - 1'b1) begin
					state <= WRITE;
				end else begin
					ch <= ch + 1'b1;
					state <= CODE;
				end
				WRITE: begin
					ch <= '0;
					state <= CODE;
					if (col != map_size - 1'b1) begin
						col <= col + 1'b1;
					end else begin
						col <= '0;
						if (row != map_size - 1'b1) begin
							row <= row + 1'b1;
						end else begin
							row <= '0;
							if (kernel == n_ker - 1'b1) begin
								state <= DONE;
							end else begin
								kernel <= kernel + 1'b1;
								state <= BIAS;
							end
						end
					end
				end
				// last write goes out this cycle
				DONE: begin
					finish <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign bias_rd = (state == BIAS) && !step;
	assign bias_load = (state == BIAS) && step;
	assign code_rd = (state == CODE) && !step;
	assign code_load = (state == CODE) && step;
	assign pixel_start = code_load && (ch == '0);
	assign tap_req = (state == TAPS);
	assign out_wr_req = (state == WRITE);

	assign bias_addr = addr_t'(kernel);
	assign code_addr = addr_t'(kernel) * addr_t'(n_ch) + addr_t'(ch);
	assign plane = addr_t'(map_size) * addr_t'(map_size);
	assign wr_addr = addr_t'(kernel) * plane + addr_t'(row) * addr_t'(map_size) + addr_t'(col);

endmodule

/* logic/window_fetch.sv */
`timescale 1ns/1ns
`include "conv_macros.svh"

module window_fetch (
	input  logic            clk,
	input  logic            rst,
	input  logic            tap_req,
	input  conv_pkg::tap_t  tap,
	input  conv_pkg::dim_t  row,
	input  conv_pkg::dim_t  col,
	input  conv_pkg::cnt_t  ch,
	input  conv_pkg::dim_t  num_row,
	output conv_pkg::addr_t in_addr,
	output logic            in_rd,
	input  conv_pkg::data_t in_data,
	output logic            tap_valid,
	output conv_pkg::tap_t  tap_index,
	output conv_pkg::data_t tap_data
);
	import conv_pkg::*;

	logic [1:0] tr;
	logic [1:0] tc;
	// coordinates shifted by one so the top/left pad is zero
	logic [`DIM_W:0] r_p;
	logic [`DIM_W:0] c_p;
	logic pad;
	logic pad_q;
	addr_t plane;

	always_comb begin
		if (tap < tap_t'(3)) begin
			tr = 2'd0;
			tc = 2'(tap);
		end else if (tap < tap_t'(6)) begin
			tr = 2'd1;
			tc = 2'(tap - tap_t'(3));
		end else begin
			tr = 2'd2;
			tc = 2'(tap - tap_t'(6));
		end
	end

	assign r_p = {1'b0, row} + tr;
	assign c_p = {1'b0, col} + tc;
	assign pad = (r_p == '0) || (c_p == '0) || (r_p > num_row) || (c_p > num_row);

	assign plane = addr_t'(num_row) * addr_t'(num_row);
	assign in_addr = addr_t'(ch) * plane + addr_t'(r_p - 1'b1) * addr_t'(num_row)
		+ addr_t'(c_p - 1'b1);
	// padding taps never touch memory
	assign in_rd = tap_req && !pad;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tap_valid <= 1'b0;
			pad_q <= 1'b0;
		end else begin
			tap_valid <= tap_req;
			pad_q <= pad;
		end
	end

	always_ff @(posedge clk) begin
		tap_index <= tap;
	end

	assign tap_data = pad_q ? '0 : in_data;

endmodule

/* logic/weight_decode.sv */
`timescale 1ns/1ns
`include "conv_macros.svh"

module weight_decode (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  conv_pkg::codebook_t w8,
	input  logic                code_load,
	input  conv_pkg::code_word_t code_data,
	input  conv_pkg::tap_t      tap_index,
	output conv_pkg::weight_t   weight
);
	import conv_pkg::*;

	codebook_t book;
	code_word_t code_word;
	logic [`CODE_W-1:0] code;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			book <= '0;
			code_word <= '0;
		end else begin
			if (start)
				book <= w8;
			if (code_load)
				code_word <= code_data;
		end
	end

	// code of the returning tap picks one codebook byte
	assign code = code_word[tap_index*`CODE_W +: `CODE_W];
	assign weight = weight_t'(book[code*`DATA_W +: `DATA_W]);

endmodule

/* logic/mac_unit.sv */
`timescale 1ns/1ns
`include "conv_macros.svh"

module mac_unit (
	input  logic              clk,
	input  logic              rst,
	input  logic              bias_load,
	input  conv_pkg::bias_t   bias_data,
	input  logic              pixel_start,
	input  logic              tap_valid,
	input  conv_pkg::data_t   tap_data,
	input  conv_pkg::weight_t weight,
	output conv_pkg::acc_t    acc
);
	import conv_pkg::*;

	bias_t bias_q;
	logic signed [2*`DATA_W-1:0] prod;

	// held for the whole kernel
	always_ff @(posedge clk) begin
		if (bias_load)
			bias_q <= bias_data;
	end

	assign prod = tap_data * weight;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			acc <= '0;
		else if (pixel_start)
			acc <= acc_t'(bias_q);
		else if (tap_valid)
			acc <= acc + acc_t'(prod);
	end

endmodule

/* logic/output_quant.sv */
`timescale 1ns/1ns
`include "conv_macros.svh"

module output_quant (
	input  logic            clk,
	input  logic            rst,
	input  logic            out_wr_req,
	input  conv_pkg::addr_t addr_in,
	input  conv_pkg::acc_t  acc,
	output logic            out_wr,
	output conv_pkg::addr_t out_addr,
	output conv_pkg::data_t out_data
);
	import conv_pkg::*;

	acc_t shifted;
	data_t clamped;

	assign shifted = acc >>> `QUANT_SHIFT;

	// saturate to int8
	always_comb begin
		if (shifted > 127)
			clamped = 8'sh7f;
		else if (shifted < -128)
			clamped = 8'sh80;
		else
			clamped = data_t'(shifted);
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			out_wr <= 1'b0;
		else
			out_wr <= out_wr_req;
	end

	always_ff @(posedge clk) begin
		if (out_wr_req) begin
			out_addr <= addr_in;
			out_data <= clamped;
		end
	end

endmodule

/* logic/conv_top.sv */
`timescale 1ns/1ns

module conv_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  conv_pkg::codebook_t  w8,
	input  conv_pkg::dim_t       num_row,
	input  conv_pkg::cnt_t       num_channel,
	input  conv_pkg::cnt_t       num_kernel,
	output logic                 finish,
	output conv_pkg::addr_t      in_addr,
	output logic                 in_rd,
	input  conv_pkg::data_t      in_data,
	output conv_pkg::addr_t      code_addr,
	output logic                 code_rd,
	input  conv_pkg::code_word_t code_data,
	output conv_pkg::addr_t      bias_addr,
	output logic                 bias_rd,
	input  conv_pkg::bias_t      bias_data,
	output conv_pkg::addr_t      out_addr,
	output logic                 out_wr,
	output conv_pkg::data_t      out_data
);
	import conv_pkg::*;

	dim_t row;
	dim_t col;
	dim_t map_size;
	cnt_t ch;
	tap_t tap;
	tap_t tap_index;
	logic tap_req;
	logic tap_valid;
	logic bias_load;
	logic code_load;
	logic pixel_start;
	logic out_wr_req;
	addr_t wr_addr;
	data_t tap_data;
	weight_t weight;
	acc_t acc;

	conv_ctrl u_ctrl (
		.clk(clk), .rst(rst), .start(start),
		.num_row(num_row), .num_channel(num_channel), .num_kernel(num_kernel),
		.finish(finish), .state(), .row(row), .col(col), .ch(ch), .kernel(),
		.tap(tap), .tap_req(tap_req), .code_rd(code_rd), .code_addr(code_addr),
		.bias_rd(bias_rd), .bias_addr(bias_addr), .bias_load(bias_load),
		.code_load(code_load), .pixel_start(pixel_start), .out_wr_req(out_wr_req),
		.wr_addr(wr_addr), .map_size(map_size)
	);

	window_fetch u_fetch (
		.clk(clk), .rst(rst), .tap_req(tap_req), .tap(tap),
		.row(row), .col(col), .ch(ch), .num_row(map_size),
		.in_addr(in_addr), .in_rd(in_rd), .in_data(in_data),
		.tap_valid(tap_valid), .tap_index(tap_index), .tap_data(tap_data)
	);

	weight_decode u_weight (
		.clk(clk), .rst(rst), .start(start), .w8(w8),
		.code_load(code_load), .code_data(code_data),
		.tap_index(tap_index), .weight(weight)
	);

	mac_unit u_mac (
		.clk(clk), .rst(rst), .bias_load(bias_load), .bias_data(bias_data),
		.pixel_start(pixel_start), .tap_valid(tap_valid), .tap_data(tap_data),
		.weight(weight), .acc(acc)
	);

	output_quant u_quant (
		.clk(clk), .rst(rst), .out_wr_req(out_wr_req), .addr_in(wr_addr), .acc(acc),
		.out_wr(out_wr), .out_addr(out_addr), .out_data(out_data)
	);

endmodule

/* tests/conv_tb.sv */
`timescale 1ns/1ns
`include "conv_macros.svh"

module conv_tb;
	import conv_pkg::*;

	logic clk;
	logic rst;
	logic start;
	codebook_t w8;
	dim_t num_row;
	cnt_t num_channel;
	cnt_t num_kernel;
	logic finish;
	addr_t in_addr;
	logic in_rd;
	data_t in_data;
	addr_t code_addr;
	logic code_rd;
	code_word_t code_data;
	addr_t bias_addr;
	logic bias_rd;
	bias_t bias_data;
	addr_t out_addr;
	logic out_wr;
	data_t out_data;

	data_t in_mem [0:1023];
	code_word_t code_mem [0:63];
	bias_t bias_mem [0:15];
	data_t out_mem [0:1023];
	data_t exp_mem [0:1023];
	data_t prev_out [0:1023];
	codebook_t cur_book;
	int seed;
	int errors;
	int checks;
	int tests_run;
	int wr_count;
	int rd_count;

	conv_top uut (
		.clk(clk), .rst(rst), .start(start), .w8(w8),
		.num_row(num_row), .num_channel(num_channel), .num_kernel(num_kernel),
		.finish(finish),
		.in_addr(in_addr), .in_rd(in_rd), .in_data(in_data),
		.code_addr(code_addr), .code_rd(code_rd), .code_data(code_data),
		.bias_addr(bias_addr), .bias_rd(bias_rd), .bias_data(bias_data),
		.out_addr(out_addr), .out_wr(out_wr), .out_data(out_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// read ports answer one cycle after the strobe
	always @(posedge clk) begin
		if (in_rd) begin
			in_data <= in_mem[in_addr];
			rd_count = rd_count + 1;
		end
		if (code_rd)
			code_data <= code_mem[code_addr];
		if (bias_rd)
			bias_data <= bias_mem[bias_addr];
		if (out_wr) begin
			// outputs leave in kernel, row, column order
			check_addr("out_addr", addr_t'(wr_count), out_addr);
			out_mem[out_addr] = out_data;
			wr_count = wr_count + 1;
		end
	end

	task automatic check_data(input string name, input data_t exp, input data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("MISMATCH t=%0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic tick;
		@(posedge clk);
		#2;
	endtask

	function automatic int cycle_bound(input int nr, input int nch, input int nk);
		// bias 2, then per channel code 2 + taps 9 + mac 1, one write per pixel
		return nk * (2 + nr * nr * (nch * 12 + 1)) + 20;
	endfunction

	function automatic int codebook_weight(input int code);
		return int'($signed(cur_book[code*8 +: 8]));
	endfunction

	task automatic fill_memories(input int nr, input int nch, input int nk,
		input int data_mag, input int bias_mag);
		for (int i = 0; i < nch * nr * nr; i++)
			in_mem[i] = data_t'($random(seed) % data_mag);
		for (int i = 0; i < nk * nch; i++)
			code_mem[i] = code_word_t'($random(seed));
		for (int i = 0; i < nk; i++)
			bias_mem[i] = bias_t'($random(seed) % bias_mag);
	endtask

	// padded 3x3 convolution, channel sum, shift and clamp
	task automatic compute_expected(input int nr, input int nch, input int nk);
		int acc;
		int r2;
		int c2;
		int px;
		int v;
		code_word_t cw;
		for (int k = 0; k < nk; k++)
			for (int r = 0; r < nr; r++)
				for (int c = 0; c < nr; c++) begin
					acc = int'(bias_mem[k]);
					for (int ch = 0; ch < nch; ch++) begin
						cw = code_mem[k * nch + ch];
						for (int t = 0; t < `TAPS; t++) begin
							r2 = r + t / 3 - 1;
							c2 = c + t % 3 - 1;
							px = 0;
							if (r2 >= 0 && r2 < nr && c2 >= 0 && c2 < nr)
								px = int'(in_mem[ch * nr * nr + r2 * nr + c2]);
							acc += px * codebook_weight(int'(cw[t*`CODE_W +: `CODE_W]));
						end
					end
					v = acc >>> `QUANT_SHIFT;
					if (v > 127)
						v = 127;
					else if (v < -128)
						v = -128;
					exp_mem[k * nr * nr + r * nr + c] = data_t'(v);
				end
	endtask

	task automatic wait_finish(input int bound);
		int n;
		n = 0;
		while (!finish && n < bound) begin
			tick;
			n++;
		end
		if (!finish) begin
			errors++;
			$display("finish did not rise within %0d cycles", bound);
		end
	endtask

	task automatic run_conv(input int nr, input int nch, input int nk);
		for (int i = 0; i < 1024; i++)
			out_mem[i] = 'x;
		wr_count = 0;
		rd_count = 0;
		num_row = dim_t'(nr);
		num_channel = cnt_t'(nch);
		num_kernel = cnt_t'(nk);
		w8 = cur_book;
		start = 1'b1;
		tick;
		start = 1'b0;
		// sizes and codebook only count at start
		w8 = ~cur_book;
		num_row = '0;
		num_channel = '0;
		num_kernel = '0;
		check_bit("finish", 1'b0, finish);
		wait_finish(cycle_bound(nr, nch, nk));
		check_bit("finish", 1'b1, finish);
		check_count("write count", nk * nr * nr, wr_count);
		// padding taps are never read
		check_count("in_rd count", nk * nch * (3 * nr - 2) * (3 * nr - 2), rd_count);
		compute_expected(nr, nch, nk);
		for (int i = 0; i < nk * nr * nr; i++)
			check_data($sformatf("out_mem[%0d]", i), exp_mem[i], out_mem[i]);
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before)
			$display("%s: ok", name);
		else
			$display("%s: FAILED with %0d errors", name, errors - err_before);
	endtask

	task automatic test_reset;
		int e;
		e = errors;
		for (int i = 0; i < 2; i++) begin
			check_bit("finish", 1'b0, finish);
			check_bit("out_wr", 1'b0, out_wr);
			check_bit("in_rd", 1'b0, in_rd);
			check_bit("code_rd", 1'b0, code_rd);
			check_bit("bias_rd", 1'b0, bias_rd);
			tick;
		end
		end_test("reset", e);
	endtask

	task automatic test_single_channel;
		int e;
		e = errors;
		cur_book = codebook_t'($random(seed));
		fill_memories(4, 1, 1, 32, 4096);
		run_conv(4, 1, 1);
		end_test("single_channel", e);
	endtask

	task automatic test_codebook;
		int e;
		e = errors;
		cur_book = 32'h81_3c_f5_0b;
		fill_memories(3, 2, 1, 32, 4096);
		// every tap code value appears in each word
		for (int ch = 0; ch < 2; ch++)
			for (int t = 0; t < `TAPS; t++)
				code_mem[ch][t*`CODE_W +: `CODE_W] = 2'((t + ch) % 4);
		run_conv(3, 2, 1);
		end_test("codebook", e);
	endtask

	task automatic test_multi_kernel;
		int e;
		e = errors;
		cur_book = codebook_t'($random(seed));
		fill_memories(5, 3, 2, 32, 4096);
		run_conv(5, 3, 2);
		end_test("multi_kernel", e);
	endtask

	task automatic test_saturation;
		int e;
		e = errors;
		cur_book = 32'h02_fe_ff_01;
		fill_memories(4, 2, 2, 8, 16);
		bias_mem[0] = 16'sd30000;
		bias_mem[1] = -16'sd30000;
		run_conv(4, 2, 2);
		for (int i = 0; i < 16; i++) begin
			check_data($sformatf("out_mem[%0d]", i), 8'sd127, out_mem[i]);
			check_data($sformatf("out_mem[%0d]", i + 16), -8'sd128, out_mem[i + 16]);
		end
		end_test("saturation", e);
	endtask

	task automatic test_restart;
		int e;
		e = errors;
		cur_book = codebook_t'($random(seed));
		fill_memories(3, 2, 2, 32, 4096);
		run_conv(3, 2, 2);
		for (int i = 0; i < 18; i++)
			prev_out[i] = out_mem[i];
		// finish holds until the next start
		repeat (5) begin
			tick;
			check_bit("finish", 1'b1, finish);
		end
		run_conv(3, 2, 2);
		for (int i = 0; i < 18; i++)
			check_data($sformatf("rerun out_mem[%0d]", i), prev_out[i], out_mem[i]);
		end_test("restart", e);
	endtask

	initial begin
		int limit;
		limit = 16 + 10 + 5 + cycle_bound(4, 1, 1) + cycle_bound(3, 2, 1)
			+ cycle_bound(5, 3, 2) + cycle_bound(4, 2, 2) + 2 * cycle_bound(3, 2, 2);
		limit = 2 * limit;
		repeat (limit) @(posedge clk);
		$display("watchdog: run did not complete within %0d cycles", limit);
		$display("Checks failed");
		$finish;
	end

	initial begin
		seed = 32'h728d_e8a5;
		errors = 0;
		checks = 0;
		tests_run = 0;
		wr_count = 0;
		rd_count = 0;
		rst = 1'b0;
		start = 1'b0;
		w8 = '0;
		num_row = '0;
		num_channel = '0;
		num_kernel = '0;
		in_data <= '0;
		code_data <= '0;
		bias_data <= '0;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b1;
		test_reset;
		test_single_channel;
		test_codebook;
		test_multi_kernel;
		test_saturation;
		test_restart;
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* files.f */
+incdir+logic
logic/conv_pkg.sv
logic/conv_ctrl.sv
logic/window_fetch.sv
logic/weight_decode.sv
logic/mac_unit.sv
logic/output_quant.sv
logic/conv_top.sv
tests/conv_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f files.f --top-module conv_tb -Mdir obj_dir -o conv_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/conv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
